// File: verilog/qaz_bus_pkg.sv
// ==========================================================================
// register bus definitions: widths, register map, reset values and the
// shared register word with its control and display views
// ==========================================================================

package qaz_bus_pkg;

  // ========================================================================
  // bus geometry
  // ========================================================================
  localparam int bus_data_width   = 32;
  localparam int bus_decode_width = 20;                 // low address bits only

  // ========================================================================
  // register map
  // ========================================================================
  localparam logic [bus_decode_width-1:0] reg_offset_ctrl = 20'h0_0000;
  localparam logic [bus_decode_width-1:0] reg_offset_hex  = 20'h0_0004;

  localparam int ctrl_soft_rst_bit = 0;                 // self clearing
  localparam int ctrl_audio_en_bit = 4;

  localparam logic [bus_data_width-1:0] hex_reset_value = 32'h0000_ffff;
  localparam logic [bus_data_width-1:0] bad_addr_word   = 32'h1bad_c0de;

  typedef enum logic [1:0] {
    sel_ctrl,
    sel_hex,
    sel_none                                            // unmapped address
  } reg_sel_t;

  // control register layout, msb first
  typedef struct packed {
    logic [26:0] reserved_hi;
    logic        audio_en;
    logic [2:0]  reserved_lo;
    logic        soft_rst;
  } ctrl_word_t;

  // display register layout, digit[0] is the rightmost digit
  typedef struct packed {
    logic [15:0]      unused;
    logic [3:0][3:0]  digit;
  } hex_word_t;

  typedef union packed {
    logic [bus_data_width-1:0] raw;
    ctrl_word_t                ctrl;
    hex_word_t                 hex;
  } reg_word_u;

endpackage

// File: verilog/qaz_display_pkg.sv
// ==========================================================================
// seven-segment display definitions and the hex digit pattern table
// ==========================================================================

package qaz_display_pkg;

  localparam int hex_digit_count = 4;
  localparam int seg_width       = 7;

  // active low, bit 0 is segment a, bit 6 is segment g
  typedef logic [seg_width-1:0] seg_t;

  // ========================================================================
  // patterns for 0 to F
  // ========================================================================
  localparam seg_t seg_table [16] = '{
    7'b1000000,                                         // 0
    7'b1111001,                                         // 1
    7'b0100100,                                         // 2
    7'b0110000,                                         // 3
    7'b0011001,                                         // 4
    7'b0010010,                                         // 5
    7'b0000010,                                         // 6
    7'b1111000,                                         // 7
    7'b0000000,                                         // 8
    7'b0010000,                                         // 9
    7'b0001000,                                         // A
    7'b0000011,                                         // b
    7'b1000110,                                         // C
    7'b0100001,                                         // d
    7'b0000110,                                         // E
    7'b0001110                                          // F
  };

endpackage

// File: verilog/qaz_reg_if.sv
// ==========================================================================
// register access channel between the bus slave and the register block
// ==========================================================================

interface qaz_reg_if;

  import qaz_bus_pkg::*;

  reg_sel_t                  sel;                       // target register
  logic                      wr_stb;                    // qualified write
  reg_word_u                 wr_data;
  logic [bus_data_width-1:0] rd_data;                   // combinational from sel

  // ========================================================================
  // bus slave side
  // ========================================================================
  modport slave (
    output sel,
    output wr_stb,
    output wr_data,
    input  rd_data
  );

  // ========================================================================
  // register block side
  // ========================================================================
  modport regs (
    input  sel,
    input  wr_stb,
    input  wr_data,
    output rd_data
  );

endinterface

// File: verilog/qaz_reset_sync.sv
// ==========================================================================
// reset synchronizer, merges external and soft reset requests into one
// synchronous active high system reset
// ==========================================================================

module qaz_reset_sync (
  input  logic sys_clk_i,
  input  logic async_rst_i,
  input  logic soft_rst_i,
  output logic sys_rst_o
);

  logic       rst_req;
  logic [1:0] sync_q;                                   // [0] first stage

  assign rst_req = async_rst_i | soft_rst_i;            // either source resets

  // two flop chain, no reset of its own
  always_ff @(posedge sys_clk_i) begin
    sync_q[0] <= rst_req;
    sync_q[1] <= sync_q[0];
  end

  assign sys_rst_o = sync_q[1];

  // ========================================================================
  // checks
  // ========================================================================

  // external reset must reach the system within the sync latency
  a_async_rst_reaches_sys : assert property (
    @(posedge sys_clk_i) async_rst_i |-> ##[1:3] sys_rst_o
  ) else $error("async reset did not reach sys_rst_o in time");

  // a soft request that is held also gets through
  a_soft_rst_reaches_sys : assert property (
    @(posedge sys_clk_i) (soft_rst_i && !sys_rst_o) |-> ##[1:3] sys_rst_o
  ) else $error("soft reset did not reach sys_rst_o in time");

endmodule

// File: verilog/qaz_bus_slave.sv
// ==========================================================================
// register bus slave, decodes single cycle transfers into register
// selects and write strobes, and returns read data with a same cycle ack
// ==========================================================================

module qaz_bus_slave (
  input  logic                                 sys_clk_i,
  input  logic                                 sys_rst_o,
  input  logic [qaz_bus_pkg::bus_data_width-1:0] sys_addr_i,
  input  logic [qaz_bus_pkg::bus_data_width-1:0] sys_data_i,
  input  logic                                 sys_we_i,
  input  logic                                 sys_cyc_i,
  input  logic                                 sys_stb_i,
  output logic [qaz_bus_pkg::bus_data_width-1:0] sys_data_o,
  output logic                                 sys_ack_o,
  qaz_reg_if.slave                             reg_bus
);

  import qaz_bus_pkg::*;

  logic                        transfer;
  logic [bus_decode_width-1:0] offset;

  assign transfer = sys_cyc_i & sys_stb_i;              // no wait states
  assign offset   = sys_addr_i[bus_decode_width-1:0];   // upper bits alias

  // ========================================================================
  // address decode
  // ========================================================================
  always_comb begin
    case (offset)
      reg_offset_ctrl: reg_bus.sel = sel_ctrl;
      reg_offset_hex:  reg_bus.sel = sel_hex;
      default:         reg_bus.sel = sel_none;
    endcase
  end

  assign reg_bus.wr_stb  = transfer & sys_we_i;
  assign reg_bus.wr_data = sys_data_i;                  // each register picks its view

  // ========================================================================
  // read return and handshake
  // ========================================================================
  assign sys_data_o = (reg_bus.sel == sel_none) ? bad_addr_word : reg_bus.rd_data;
  assign sys_ack_o  = transfer;

  // ========================================================================
  // checks
  // ========================================================================

  // a register read, an unmapped write, then the same register read again
  // must return the same word when no reset falls in between
  a_unmapped_write_harmless : assert property (
    @(posedge sys_clk_i)
      (reg_bus.sel != sel_none && !reg_bus.wr_stb && !sys_rst_o)
      ##1 (reg_bus.wr_stb && reg_bus.sel == sel_none && !sys_rst_o)
      ##1 (reg_bus.sel == $past(reg_bus.sel, 2))
      |-> (reg_bus.rd_data == $past(reg_bus.rd_data, 2))
  ) else $error("unmapped write changed a register");

endmodule

// File: verilog/qaz_control_regs.sv
// ==========================================================================
// system control registers: soft reset, audio clock enable and the
// hex display word, with the read data mux
// ==========================================================================

module qaz_control_regs (
  input  logic        sys_clk_i,
  input  logic        sys_rst_o,
  qaz_reg_if.regs     reg_bus,
  output logic        soft_rst_o,
  output logic        audio_clk_en_o,
  output logic [15:0] hex_value_o
);

  import qaz_bus_pkg::*;

  logic                      soft_rst_q;
  logic                      audio_en_q;
  reg_word_u                 display_q;                 // full 32 bit word kept
  logic [bus_data_width-1:0] ctrl_word;
  logic                      wr_ctrl;
  logic                      wr_hex;

  assign wr_ctrl = reg_bus.wr_stb && (reg_bus.sel == sel_ctrl);
  assign wr_hex  = reg_bus.wr_stb && (reg_bus.sel == sel_hex);

  // ========================================================================
  // offset 0x0, control
  // ========================================================================
  always_ff @(posedge sys_clk_i) begin
    if (sys_rst_o) begin
      soft_rst_q <= 1'b0;                               // clears itself via the reset
      audio_en_q <= 1'b0;
    end else if (wr_ctrl) begin
      soft_rst_q <= reg_bus.wr_data.ctrl.soft_rst;
      audio_en_q <= reg_bus.wr_data.ctrl.audio_en;
    end
  end

  // reserved bits read back as zero
  always_comb begin
    ctrl_word                    = '0;
    ctrl_word[ctrl_soft_rst_bit] = soft_rst_q;
    ctrl_word[ctrl_audio_en_bit] = audio_en_q;
  end

  // ========================================================================
  // offset 0x4, hex display
  // ========================================================================
  always_ff @(posedge sys_clk_i) begin
    if (sys_rst_o) begin
      display_q.raw <= hex_reset_value;                 // shows FFFF
    end else if (wr_hex) begin
      display_q.raw <= reg_bus.wr_data.raw;
    end
  end

  // ========================================================================
  // read mux and outputs
  // ========================================================================
  always_comb begin
    case (reg_bus.sel)
      sel_ctrl: reg_bus.rd_data = ctrl_word;
      sel_hex:  reg_bus.rd_data = display_q.raw;
      default:  reg_bus.rd_data = '0;                   // slave substitutes marker
    endcase
  end

  assign soft_rst_o     = soft_rst_q;
  assign audio_clk_en_o = audio_en_q;
  assign hex_value_o    = display_q.hex.digit;

endmodule

// File: verilog/qaz_hex_display.sv
// ==========================================================================
// hex display driver, four nibbles to active low seven-segment digits
// ==========================================================================

module qaz_hex_display (
  input  logic [qaz_display_pkg::hex_digit_count*4-1:0] hex_value_i,
  output qaz_display_pkg::seg_t                         hex0_o,
  output qaz_display_pkg::seg_t                         hex1_o,
  output qaz_display_pkg::seg_t                         hex2_o,
  output qaz_display_pkg::seg_t                         hex3_o
);

  import qaz_display_pkg::*;

  seg_t digit_seg [hex_digit_count];                    // index 0 is rightmost

  // ========================================================================
  // nibble lookup
  // ========================================================================
  always_comb begin
    for (int i = 0; i < hex_digit_count; i++) begin
      digit_seg[i] = seg_table[hex_value_i[i*4 +: 4]];
    end
  end

  // ========================================================================
  // digit outputs
  // ========================================================================
  assign hex0_o = digit_seg[0];                         // lowest nibble
  assign hex1_o = digit_seg[1];
  assign hex2_o = digit_seg[2];
  assign hex3_o = digit_seg[3];                         // highest nibble

endmodule

// File: verilog/qaz_system.sv
// ==========================================================================
// system control block top: register bus slave, reset generation,
// control registers and the hex display
// ==========================================================================

module qaz_system (
  input  logic                                   sys_clk_i,
  input  logic                                   async_rst_i,
  input  logic [qaz_bus_pkg::bus_data_width-1:0] sys_addr_i,
  input  logic [qaz_bus_pkg::bus_data_width-1:0] sys_data_i,
  input  logic                                   sys_we_i,
  input  logic                                   sys_cyc_i,
  input  logic                                   sys_stb_i,
  output logic [qaz_bus_pkg::bus_data_width-1:0] sys_data_o,
  output logic                                   sys_ack_o,
  output logic                                   sys_audio_clk_en_o,
  output qaz_display_pkg::seg_t                  hex0_o,
  output qaz_display_pkg::seg_t                  hex1_o,
  output qaz_display_pkg::seg_t                  hex2_o,
  output qaz_display_pkg::seg_t                  hex3_o,
  output logic                                   sys_rst_o
);

  import qaz_display_pkg::*;

  logic                           soft_rst;             // control bit 0
  logic [hex_digit_count*4-1:0]   hex_value;

  qaz_reg_if reg_bus ();

  // ========================================================================
  // input side
  // ========================================================================
  qaz_reset_sync qaz_reset_sync_inst (
    .sys_clk_i   (sys_clk_i),
    .async_rst_i (async_rst_i),
    .soft_rst_i  (soft_rst),
    .sys_rst_o   (sys_rst_o)
  );

  qaz_bus_slave qaz_bus_slave_inst (
    .sys_clk_i  (sys_clk_i),
    .sys_rst_o  (sys_rst_o),
    .sys_addr_i (sys_addr_i),
    .sys_data_i (sys_data_i),
    .sys_we_i   (sys_we_i),
    .sys_cyc_i  (sys_cyc_i),
    .sys_stb_i  (sys_stb_i),
    .sys_data_o (sys_data_o),
    .sys_ack_o  (sys_ack_o),
    .reg_bus    (reg_bus.slave)
  );

  // ========================================================================
  // registers and display
  // ========================================================================
  qaz_control_regs qaz_control_regs_inst (
    .sys_clk_i      (sys_clk_i),
    .sys_rst_o      (sys_rst_o),
    .reg_bus        (reg_bus.regs),
    .soft_rst_o     (soft_rst),
    .audio_clk_en_o (sys_audio_clk_en_o),
    .hex_value_o    (hex_value)
  );

  qaz_hex_display qaz_hex_display_inst (
    .hex_value_i (hex_value),
    .hex0_o      (hex0_o),
    .hex1_o      (hex1_o),
    .hex2_o      (hex2_o),
    .hex3_o      (hex3_o)
  );

endmodule

// File: testbench/qaz_tb_clock.sv
// ==========================================================================
// testbench clock source, 4 ns period
// ==========================================================================

module qaz_tb_clock (
  output logic sys_clk_o
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int half_period = 2;                       // 250 MHz

  initial begin
    sys_clk_o = 1'b0;
    forever #half_period sys_clk_o = ~sys_clk_o;
  end

endmodule

// File: testbench/qaz_system_tb.sv
// ==========================================================================
// testbench for the system control block: bus reads and writes against a
// reference model, checked by assertions, with a watchdog
// ==========================================================================

module qaz_system_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import qaz_bus_pkg::*;
  import qaz_display_pkg::*;

  localparam int test_count      = 5;
  localparam int cycles_per_test = 200;
  localparam int reset_cycles    = 4;
  localparam int watchdog_cycles = test_count * cycles_per_test + reset_cycles;

  logic        sys_clk_i;
  logic        async_rst_i;
  logic [31:0] sys_addr_i;
  logic [31:0] sys_data_i;
  logic        sys_we_i;
  logic        sys_cyc_i;
  logic        sys_stb_i;
  logic [31:0] sys_data_o;
  logic        sys_ack_o;
  logic        sys_audio_clk_en_o;
  seg_t        hex0_o;
  seg_t        hex1_o;
  seg_t        hex2_o;
  seg_t        hex3_o;
  logic        sys_rst_o;
  seg_t        dut_seg [hex_digit_count];               // digits by index

  logic        model_audio;                             // reference model state
  logic [31:0] model_hex;
  logic        check_outputs;                           // off while reset settles
  integer      seed;

  qaz_tb_clock qaz_tb_clock_inst (.sys_clk_o(sys_clk_i));

  qaz_system qaz_system_inst (
    .sys_clk_i          (sys_clk_i),
    .async_rst_i        (async_rst_i),
    .sys_addr_i         (sys_addr_i),
    .sys_data_i         (sys_data_i),
    .sys_we_i           (sys_we_i),
    .sys_cyc_i          (sys_cyc_i),
    .sys_stb_i          (sys_stb_i),
    .sys_data_o         (sys_data_o),
    .sys_ack_o          (sys_ack_o),
    .sys_audio_clk_en_o (sys_audio_clk_en_o),
    .hex0_o             (hex0_o),
    .hex1_o             (hex1_o),
    .hex2_o             (hex2_o),
    .hex3_o             (hex3_o),
    .sys_rst_o          (sys_rst_o)
  );

  assign dut_seg[0] = hex0_o;
  assign dut_seg[1] = hex1_o;
  assign dut_seg[2] = hex2_o;
  assign dut_seg[3] = hex3_o;

  // ========================================================================
  // error handling and reference model
  // ========================================================================
  task automatic report_mismatch(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic reset_model();
    model_audio = 1'b0;
    model_hex   = 32'h0000_ffff;                        // display shows FFFF
  endtask

  function automatic logic [31:0] expected_read_word(input logic [31:0] addr);
    logic [19:0] offset;
    offset = addr[19:0];                                // upper bits alias
    if (offset == 20'h0_0000) begin
      expected_read_word = {27'b0, model_audio, 4'b0};
    end else if (offset == 20'h0_0004) begin
      expected_read_word = model_hex;
    end else begin
      expected_read_word = 32'h1bad_c0de;
    end
  endfunction

  // ========================================================================
  // bus tasks, inputs change on the falling edge
  // ========================================================================
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    @(negedge sys_clk_i);
    sys_cyc_i  = 1'b1;
    sys_stb_i  = 1'b1;
    sys_we_i   = 1'b1;
    sys_addr_i = addr;
    sys_data_i = data;
    @(posedge sys_clk_i);                               // write lands here
    if (addr[19:0] == 20'h0_0000) begin
      model_audio = data[4];
    end else if (addr[19:0] == 20'h0_0004) begin
      model_hex = data;
    end
  endtask

  task automatic bus_read(input logic [31:0] addr);
    logic [31:0] expected;
    @(negedge sys_clk_i);
    sys_cyc_i  = 1'b1;
    sys_stb_i  = 1'b1;
    sys_we_i   = 1'b0;
    sys_addr_i = addr;
    #1;                                                 // mid low phase
    expected = expected_read_word(addr);
    assert (sys_data_o === expected) else
      report_mismatch($sformatf("read at 0x%08h gave 0x%08h, expected 0x%08h",
                                addr, sys_data_o, expected));
    @(posedge sys_clk_i);
  endtask

  task automatic bus_idle();
    @(negedge sys_clk_i);
    sys_cyc_i = 1'b0;
    sys_stb_i = 1'b0;
    sys_we_i  = 1'b0;
  endtask

  task automatic wait_reset_release(input int max_cycles);
    int waited;
    waited = 0;
    @(negedge sys_clk_i);
    while (sys_rst_o !== 1'b0 && waited < max_cycles) begin
      @(negedge sys_clk_i);
      waited++;
    end
    if (sys_rst_o !== 1'b0) abort_run("sys_rst_o was not released after reset");
  endtask

  // ========================================================================
  // checks
  // ========================================================================
  a_ack_follows_strobe : assert property (
    @(posedge sys_clk_i) sys_ack_o == (sys_cyc_i && sys_stb_i)
  ) else report_mismatch("ack does not follow cyc and stb");

  // register driven outputs are stable at the falling edge
  always @(negedge sys_clk_i) begin
    if (check_outputs) begin
      assert (sys_audio_clk_en_o === model_audio) else
        report_mismatch("audio clock enable differs from model");
      for (int d = 0; d < hex_digit_count; d++) begin
        assert (dut_seg[d] === seg_table[model_hex[d*4 +: 4]]) else
          report_mismatch($sformatf("digit %0d shows %b", d, dut_seg[d]));
      end
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge sys_clk_i);
    $display("watchdog timeout, run did not finish within %0d cycles", watchdog_cycles);
    $display("TEST FAIL");
    $fatal(1);
  end

  // ========================================================================
  // stimulus
  // ========================================================================
  initial begin
    logic [31:0] data;
    logic [31:0] addr;
    logic        rst_seen;
    seed          = 31854;
    check_outputs = 1'b0;
    async_rst_i   = 1'b1;
    sys_addr_i    = '0;
    sys_data_i    = '0;
    sys_we_i      = 1'b0;
    sys_cyc_i     = 1'b0;
    sys_stb_i     = 1'b0;
    reset_model();
    repeat (reset_cycles) @(posedge sys_clk_i);
    @(negedge sys_clk_i);
    async_rst_i = 1'b0;
    wait_reset_release(16);
    check_outputs = 1'b1;

    bus_read(32'h0);                                    // reset values
    bus_read(32'h4);
    bus_idle();

    for (int i = 0; i < 20; i++) begin                  // back to back pairs
      data = $random(seed);
      bus_write(32'h4, data);
      bus_read(32'h4);
    end
    bus_idle();

    data = $random(seed);
    data[0] = 1'b0;
    data[4] = 1'b1;
    bus_write(32'h0, data);
    bus_read(32'h0);                                    // only bit 4 comes back
    data = $random(seed);
    data[0] = 1'b0;
    data[4] = 1'b0;
    bus_write(32'h0, data);
    bus_read(32'h0);
    bus_write(32'h0, 32'h0000_0010);
    bus_idle();

    for (int i = 0; i < 20; i++) begin
      addr = $random(seed);
      if (addr[19:0] == 20'h0 || addr[19:0] == 20'h4) addr[19:0] = 20'h8;
      data = $random(seed);
      bus_read(32'h4);
      bus_write(addr, data);
      bus_read(32'h4);
      bus_read(addr);
      bus_read(32'h0);
    end
    for (int i = 0; i < 4; i++) begin                   // upper address aliases
      addr = $random(seed);
      addr[31:20] = addr[31:20] | 12'h001;
      addr[19:0]  = (i % 2 == 0) ? 20'h4 : 20'h0;
      data = $random(seed);
      data[0] = 1'b0;
      bus_write(addr, data);
      bus_read(addr);
      bus_read({12'h0, addr[19:0]});
    end
    bus_idle();

    bus_write(32'h4, $random(seed));
    bus_write(32'h0, 32'h0000_0010);
    bus_idle();
    check_outputs = 1'b0;
    bus_write(32'h0, 32'h0000_0011);                    // soft reset plus audio
    bus_idle();
    rst_seen = 1'b0;
    for (int c = 0; c < 4; c++) begin
      @(negedge sys_clk_i);
      if (sys_rst_o === 1'b1) rst_seen = 1'b1;
    end
    assert (rst_seen) else report_mismatch("no sys_rst_o pulse within 4 cycles of soft reset");
    wait_reset_release(16);
    reset_model();
    check_outputs = 1'b1;
    bus_read(32'h0);
    bus_read(32'h4);
    bus_idle();
    repeat (2) @(negedge sys_clk_i);

    $display("TEST PASS");
    $finish;
  end

endmodule

// File: qaz_system.f
verilog/qaz_bus_pkg.sv
verilog/qaz_display_pkg.sv
verilog/qaz_reg_if.sv
verilog/qaz_reset_sync.sv
verilog/qaz_bus_slave.sv
verilog/qaz_control_regs.sv
verilog/qaz_hex_display.sv
verilog/qaz_system.sv
testbench/qaz_tb_clock.sv
testbench/qaz_system_tb.sv

// File: Makefile
# Verilator build and run for the system control block testbench

VERILATOR ?= verilator
TOP       := qaz_system_tb
FILELIST  := qaz_system.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
